// File: Makefile
# Verilator build and run for the recovery pipeline

VERILATOR ?= verilator
TOP       ?= neural_recovery_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hidden_layer.sv
// Hidden layer pipeline
`timescale 1ns/1ns

module hidden_layer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sample_valid,
    input  neural_recovery_pkg::sample_t  noisy,
    output logic                          hidden_valid,
    output neural_recovery_pkg::hidden_t  hidden
);

    // Number of register stages from sample to hidden value
    localparam int STAGES = 4;

    neural_recovery_pkg::sample_t  noisy_q;
    neural_recovery_pkg::hidden_t  operand_q;
    neural_recovery_pkg::product_t mult_out;
    neural_recovery_pkg::product_t product_q;

    // Bit n set means stage n holds a real sample
    logic [STAGES-1:0] valid_pipe;

    // Valid tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[STAGES-2:0], sample_valid};
        end
    end

    // Stage 1 input latch
    always_ff @(posedge clk) begin
        noisy_q <= noisy;
    end

    // Stage 2 zero-extended multiplicand
    always_ff @(posedge clk) begin
        operand_q <= {{(neural_recovery_pkg::WORD_W - neural_recovery_pkg::SAMPLE_W){1'b0}},
                      noisy_q};
    end

    reduction_multiplier #(
        .COEFF (neural_recovery_pkg::HIDDEN_WEIGHT)
    ) u_mult (
        .multiplicand (operand_q),
        .product      (mult_out)
    );

    // Stage 3 product register
    always_ff @(posedge clk) begin
        product_q <= mult_out;
    end

    // Stage 4 hidden latch
    always_ff @(posedge clk) begin
        hidden <= product_q;
    end

    assign hidden_valid = valid_pipe[STAGES-1];

endmodule

// File: neural_recovery.sv
// Two-layer recovery pipeline top
`timescale 1ns/1ns

module neural_recovery (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sample_valid,
    input  neural_recovery_pkg::sample_t  noisy,
    output logic                          clean_valid,
    output neural_recovery_pkg::sample_t  clean
);

    // Hidden layer to output layer
    logic                          hidden_valid;
    neural_recovery_pkg::hidden_t  hidden;

    // Sample times hidden weight, four cycles
    hidden_layer u_hidden (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .noisy        (noisy),
        .hidden_valid (hidden_valid),
        .hidden       (hidden)
    );

    // Hidden value times output weight, then threshold
    // Another four cycles, eight end to end
    output_layer u_output (
        .clk          (clk),
        .rst_n        (rst_n),
        .hidden_valid (hidden_valid),
        .hidden       (hidden),
        .clean_valid  (clean_valid),
        .clean        (clean)
    );

endmodule

// File: neural_recovery_assertions.sv
// Recovery pipeline port assertions
`timescale 1ns/1ns

module neural_recovery_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         sample_valid,
    input logic                         clean_valid,
    input neural_recovery_pkg::sample_t clean
);

    // Edges from sample capture to the edge that sees clean_valid
    localparam int LATENCY = 8;

    // Read by the testbench at the end of the run
    int unsigned fail_count = 0;

    // Reset level at each of the last LATENCY edges, newest in bit 0
    logic [LATENCY-1:0] run_hist;

    always_ff @(posedge clk) begin
        run_hist <= {run_hist[LATENCY-2:0], rst_n};
    end

    // Every output traces back to a sample taken with reset inactive ever since
    a_valid_origin: assert property (
        @(posedge clk) disable iff (!rst_n)
        clean_valid |-> ($past(sample_valid, LATENCY) && (&run_hist))
    ) else begin
        $error("clean_valid without a sample %0d cycles earlier", LATENCY);
        fail_count++;
    end

    // Only the two output codes are legal
    a_clean_code: assert property (
        @(posedge clk) disable iff (!rst_n)
        clean_valid |-> (clean == neural_recovery_pkg::CLEAN_HIGH ||
                         clean == neural_recovery_pkg::CLEAN_LOW)
    ) else begin
        $error("clean holds %h, neither high nor low code", clean);
        fail_count++;
    end

    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(clean_valid)
    ) else begin
        $error("clean_valid is unknown out of reset");
        fail_count++;
    end

endmodule

// File: neural_recovery_pkg.sv
// Neural recovery shared definitions
package neural_recovery_pkg;

    // Word widths
    localparam int SAMPLE_W = 8;
    localparam int WORD_W   = 16;

    // Noisy input sample, also used for the cleaned output value
    typedef logic [SAMPLE_W-1:0] sample_t;

    // Hidden layer value, first product kept modulo 2^16
    typedef logic [WORD_W-1:0] hidden_t;

    // Multiplier result truncated to the low 16 bits
    typedef logic [WORD_W-1:0] product_t;

    // Fixed layer weights
    localparam logic [SAMPLE_W-1:0] HIDDEN_WEIGHT = 8'h2A;
    localparam logic [SAMPLE_W-1:0] OUTPUT_WEIGHT = 8'hD3;

    // Upper product byte must be strictly above this to count as high
    localparam sample_t CLEAN_THRESHOLD = 8'h80;

    // Output codes
    localparam sample_t CLEAN_HIGH = 8'hFF;
    localparam sample_t CLEAN_LOW  = 8'h00;

endpackage

// File: neural_recovery_tb.sv
// Recovery pipeline testbench
`timescale 1ns/1ns

module neural_recovery_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int LATENCY      = 8;
    localparam int RESET_CYCLES = 2;
    localparam int DRAIN_LIMIT  = LATENCY + 4;

    // Test lengths in cycles
    localparam int QUIET_CYCLES  = 20;
    localparam int SINGLE_CYCLES = 1 + DRAIN_LIMIT + 4;
    localparam int SWEEP_CYCLES  = 256 + DRAIN_LIMIT;
    localparam int BOUND_CYCLES  = 2 + DRAIN_LIMIT;
    localparam int RANDOM_CYCLES = 200;
    localparam int MIDRST_CYCLES = 5 + 1 + RESET_CYCLES + LATENCY + 1 + DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + QUIET_CYCLES + SINGLE_CYCLES
                                   + SWEEP_CYCLES + BOUND_CYCLES
                                   + RANDOM_CYCLES + DRAIN_LIMIT + MIDRST_CYCLES + 100;

    logic                         clk;
    logic                         rst_n;
    logic                         sample_valid;
    neural_recovery_pkg::sample_t noisy;
    logic                         clean_valid;
    neural_recovery_pkg::sample_t clean;

    // Expected values and the edge each one is due at
    neural_recovery_pkg::sample_t exp_q[$];
    int                           due_q[$];

    int cycle        = 0;
    int errors       = 0;
    int out_count    = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD)) u_clk (.clk(clk));

    neural_recovery u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .noisy        (noisy),
        .clean_valid  (clean_valid),
        .clean        (clean)
    );

    bind neural_recovery neural_recovery_assertions u_assertions (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .clean_valid  (clean_valid),
        .clean        (clean)
    );

    // Upper byte of the second-layer result for one sample
    function automatic neural_recovery_pkg::sample_t upper_byte(
        input neural_recovery_pkg::sample_t s
    );
        logic [15:0] h;
        logic [15:0] r;
        h = {8'h00, s} * {8'h00, neural_recovery_pkg::HIDDEN_WEIGHT};
        r = h * {8'h00, neural_recovery_pkg::OUTPUT_WEIGHT};
        return r[15:8];
    endfunction

    function automatic neural_recovery_pkg::sample_t model_clean(
        input neural_recovery_pkg::sample_t s
    );
        if (upper_byte(s) > neural_recovery_pkg::CLEAN_THRESHOLD) begin
            return neural_recovery_pkg::CLEAN_HIGH;
        end
        return neural_recovery_pkg::CLEAN_LOW;
    endfunction

    // Output monitor, reads values settled by the previous edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n === 1'b1 && clean_valid === 1'b1) begin
            out_count++;
            if (exp_q.size() == 0) begin
                $display("ERROR at %0t: unexpected output on clean (%h)", $time, clean);
                errors++;
            end else begin
                if (clean !== exp_q[0]) begin
                    $display("MISMATCH at %0t: clean expected %h got %h",
                             $time, exp_q[0], clean);
                    errors++;
                end
                if (cycle != due_q[0]) begin
                    $display("ERROR at %0t: output came at cycle %0d instead of %0d",
                             $time, cycle, due_q[0]);
                    errors++;
                end
                void'(exp_q.pop_front());
                void'(due_q.pop_front());
            end
        end
    end

    // One cycle of stimulus, applied on the falling edge
    task automatic send(input logic v, input neural_recovery_pkg::sample_t s);
        @(negedge clk);
        sample_valid = v;
        noisy        = s;
        if (v) begin
            exp_q.push_back(model_clean(s));
            due_q.push_back(cycle + 1 + LATENCY);
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < DRAIN_LIMIT) begin
            send(1'b0, '0);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("ERROR at %0t: %0d expected outputs never arrived", $time, exp_q.size());
            errors++;
            exp_q.delete();
            due_q.delete();
        end
    endtask

    // Samples in flight are dropped, so their expected values go too
    task automatic apply_reset();
        @(negedge clk);
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        noisy        = '0;
        exp_q.delete();
        due_q.delete();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic check_count(input int start_out, input int expected);
        if (out_count - start_out != expected) begin
            $display("ERROR at %0t: %0d outputs seen, %0d expected",
                     $time, out_count - start_out, expected);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_err);
        if (errors == start_err) begin
            tests_passed++;
            $display("[%0t] %s: pass", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: FAIL with %0d errors", $time, name, errors - start_err);
        end
    endtask

    task automatic test_reset_quiet();
        int start_err;
        start_err = errors;
        repeat (QUIET_CYCLES) begin
            send(1'b0, '0);
            if (clean_valid !== 1'b0) begin
                $display("MISMATCH at %0t: clean_valid expected 0 got %b", $time, clean_valid);
                errors++;
            end
        end
        finish_test("reset quiet", start_err);
    endtask

    task automatic test_single_latency();
        int          start_err;
        int          start_out;
        int unsigned r;
        start_err = errors;
        start_out = out_count;
        r = $urandom();
        send(1'b1, r[7:0]);
        drain();
        repeat (4) send(1'b0, '0);
        check_count(start_out, 1);
        finish_test("single sample latency", start_err);
    endtask

    task automatic test_full_sweep();
        int start_err;
        int start_out;
        int i;
        start_err = errors;
        start_out = out_count;
        for (i = 0; i < 256; i++) begin
            send(1'b1, i[7:0]);
        end
        drain();
        check_count(start_out, 256);
        finish_test("full sweep", start_err);
    endtask

    // Closest samples at or below and just above the threshold
    task automatic test_threshold_boundary();
        int                           start_err;
        int                           start_out;
        int                           i;
        int                           lo_up;
        int                           hi_up;
        neural_recovery_pkg::sample_t u;
        neural_recovery_pkg::sample_t lo_s;
        neural_recovery_pkg::sample_t hi_s;
        start_err = errors;
        start_out = out_count;
        lo_up = -1;
        hi_up = 256;
        lo_s  = '0;
        hi_s  = '0;
        for (i = 0; i < 256; i++) begin
            u = upper_byte(i[7:0]);
            if (u <= neural_recovery_pkg::CLEAN_THRESHOLD && int'(u) > lo_up) begin
                lo_up = int'(u);
                lo_s  = i[7:0];
            end
            if (u > neural_recovery_pkg::CLEAN_THRESHOLD && int'(u) < hi_up) begin
                hi_up = int'(u);
                hi_s  = i[7:0];
            end
        end
        if (lo_up < 0 || hi_up > 255) begin
            $display("ERROR at %0t: no sample found on one side of the threshold", $time);
            errors++;
        end else begin
            $display("Boundary samples %h (byte %h) and %h (byte %h)", lo_s, lo_up, hi_s, hi_up);
            send(1'b1, lo_s);
            send(1'b1, hi_s);
            drain();
            check_count(start_out, 2);
        end
        finish_test("threshold boundary", start_err);
    endtask

    task automatic test_sparse_random();
        int          start_err;
        int          start_out;
        int          sent;
        int unsigned r;
        start_err = errors;
        start_out = out_count;
        sent = 0;
        repeat (RANDOM_CYCLES) begin
            r = $urandom();
            send(r[8], r[7:0]);
            if (r[8]) begin
                sent++;
            end
        end
        drain();
        check_count(start_out, sent);
        finish_test("sparse random stream", start_err);
    endtask

    task automatic test_reset_midstream();
        int          start_err;
        int          start_out;
        int unsigned r;
        start_err = errors;
        repeat (5) begin
            r = $urandom();
            send(1'b1, r[7:0]);
        end
        apply_reset();
        start_out = out_count;
        repeat (LATENCY) begin
            send(1'b0, '0);
            if (clean_valid !== 1'b0) begin
                $display("MISMATCH at %0t: clean_valid expected 0 got %b", $time, clean_valid);
                errors++;
            end
        end
        check_count(start_out, 0);
        r = $urandom();
        send(1'b1, r[7:0]);
        drain();
        check_count(start_out, 1);
        finish_test("reset mid-stream", start_err);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        noisy        = '0;
        void'($urandom(96));
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_reset_quiet();
        test_single_latency();
        test_full_sweep();
        test_threshold_boundary();
        test_sparse_random();
        test_reset_midstream();

        $display("Summary: %0d tests passed, %0d failed, %0d assertion failures",
                 tests_passed, tests_failed, u_dut.u_assertions.fail_count);
        if (tests_failed == 0 && u_dut.u_assertions.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: output_layer.sv
// Output layer pipeline with threshold
`timescale 1ns/1ns

module output_layer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hidden_valid,
    input  neural_recovery_pkg::hidden_t  hidden,
    output logic                          clean_valid,
    output neural_recovery_pkg::sample_t  clean
);

    // Register stages from hidden value to clean output
    localparam int STAGES = 4;

    neural_recovery_pkg::hidden_t  operand_q;
    neural_recovery_pkg::product_t mult_out;
    neural_recovery_pkg::product_t product_q;
    neural_recovery_pkg::product_t result_q;

    // Upper byte of the latched result, the part that gets judged
    neural_recovery_pkg::sample_t  result_hi;

    logic [STAGES-1:0] valid_pipe;

    // Valid tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[STAGES-2:0], hidden_valid};
        end
    end

    // Stage 1 multiplicand register
    always_ff @(posedge clk) begin
        operand_q <= hidden;
    end

    reduction_multiplier #(
        .COEFF (neural_recovery_pkg::OUTPUT_WEIGHT)
    ) u_mult (
        .multiplicand (operand_q),
        .product      (mult_out)
    );

    // Stage 2 product register, stage 3 result latch
    always_ff @(posedge clk) begin
        product_q <= mult_out;
        result_q  <= product_q;
    end

    assign result_hi = result_q[neural_recovery_pkg::WORD_W-1 -: neural_recovery_pkg::SAMPLE_W];

    // Stage 4 threshold decision
    // Strictly greater, so a byte equal to the threshold reads as low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clean <= neural_recovery_pkg::CLEAN_LOW;
        end else if (result_hi > neural_recovery_pkg::CLEAN_THRESHOLD) begin
            clean <= neural_recovery_pkg::CLEAN_HIGH;
        end else begin
            clean <= neural_recovery_pkg::CLEAN_LOW;
        end
    end

    assign clean_valid = valid_pipe[STAGES-1];

endmodule

// File: reduction_multiplier.sv
// Constant-coefficient multiplier
`timescale 1ns/1ns

module reduction_multiplier #(
    parameter logic [neural_recovery_pkg::SAMPLE_W-1:0] COEFF = 8'h01
) (
    input  neural_recovery_pkg::hidden_t  multiplicand,
    output neural_recovery_pkg::product_t product
);

    // One partial-product row per coefficient bit
    localparam int ROWS = neural_recovery_pkg::SAMPLE_W;

    // Rows left after each level of the adder tree
    localparam int L1_ROWS = ROWS / 2;
    localparam int L2_ROWS = L1_ROWS / 2;

    neural_recovery_pkg::product_t pp [ROWS];
    neural_recovery_pkg::product_t sum_l1 [L1_ROWS];
    neural_recovery_pkg::product_t sum_l2 [L2_ROWS];
    neural_recovery_pkg::product_t sum_l3;

    // Shifted copies of the multiplicand for every set coefficient bit
    // Bits shifted past bit 15 drop out, which is the modulo 2^16 wrap
    genvar i;
    generate
        for (i = 0; i < ROWS; i++) begin : gen_pp
            if (COEFF[i]) begin : gen_row
                assign pp[i] = multiplicand << i;
            end else begin : gen_zero
                // Constant zero row, removed by synthesis
                assign pp[i] = '0;
            end
        end
    endgenerate

    // Level 1: eight rows down to four
    genvar j;
    generate
        for (j = 0; j < L1_ROWS; j++) begin : gen_l1
            assign sum_l1[j] = pp[2*j] + pp[2*j+1];
        end
    endgenerate

    // Level 2: four rows down to two
    genvar k;
    generate
        for (k = 0; k < L2_ROWS; k++) begin : gen_l2
            assign sum_l2[k] = sum_l1[2*k] + sum_l1[2*k+1];
        end
    endgenerate

    // Level 3: final pair
    // Carries out of bit 15 are discarded at every level
    assign sum_l3 = sum_l2[0] + sum_l2[1];

    assign product = sum_l3;

endmodule

// File: src.f
neural_recovery_pkg.sv
reduction_multiplier.sv
hidden_layer.sv
output_layer.sv
neural_recovery.sv
tb_clock_gen.sv
neural_recovery_assertions.sv
neural_recovery_tb.sv

// File: tb_clock_gen.sv
// Testbench clock source
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk;

endmodule
